/* mesi_bus_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module mesi_bus_ctrl (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         p0_cyc,
   input  logic                         p0_stb,
   input  logic                         p0_we,
   input  logic [mesi_pkg::ADDR_W-1:0]  p0_adr,
   input  logic [mesi_pkg::DATA_W-1:0]  p0_dat_w,
   output logic [mesi_pkg::DATA_W-1:0]  p0_dat_r,
   output logic                         p0_ack,
   input  logic                         p1_cyc,
   input  logic                         p1_stb,
   input  logic                         p1_we,
   input  logic [mesi_pkg::ADDR_W-1:0]  p1_adr,
   input  logic [mesi_pkg::DATA_W-1:0]  p1_dat_w,
   output logic [mesi_pkg::DATA_W-1:0]  p1_dat_r,
   output logic                         p1_ack,
   output logic [mesi_pkg::ADDR_W-1:0]  lookup_adr,     // Same address to both caches
   input  logic                         c0_hit,
   input  mesi_pkg::mesi_state_t        c0_state,
   input  logic [mesi_pkg::DATA_W-1:0]  c0_data,
   input  logic [mesi_pkg::TAG_W-1:0]   c0_victim_tag,
   output logic                         c0_wr_en,
   output logic [mesi_pkg::ADDR_W-1:0]  c0_wr_adr,
   output logic [mesi_pkg::DATA_W-1:0]  c0_wr_data,
   output mesi_pkg::mesi_state_t        c0_wr_state,
   output logic                         c0_st_en,
   output mesi_pkg::mesi_state_t        c0_st_state,
   input  logic                         c1_hit,
   input  mesi_pkg::mesi_state_t        c1_state,
   input  logic [mesi_pkg::DATA_W-1:0]  c1_data,
   input  logic [mesi_pkg::TAG_W-1:0]   c1_victim_tag,
   output logic                         c1_wr_en,
   output logic [mesi_pkg::ADDR_W-1:0]  c1_wr_adr,
   output logic [mesi_pkg::DATA_W-1:0]  c1_wr_data,
   output mesi_pkg::mesi_state_t        c1_wr_state,
   output logic                         c1_st_en,
   output mesi_pkg::mesi_state_t        c1_st_state,
   output logic [mesi_pkg::ADDR_W-1:0]  mem_adr,
   output logic                         mem_re,
   output logic                         mem_we,
   output logic [mesi_pkg::DATA_W-1:0]  mem_wdata,
   input  logic [mesi_pkg::DATA_W-1:0]  mem_rdata
);

   import mesi_pkg::*;

   typedef enum logic [2:0] {
      CS_IDLE,                                 // Waiting for a request
      CS_LOOKUP,                               // Both caches looked up, action chosen
      CS_WB,                                   // Dirty victim to memory
      CS_MEM,                                  // Memory read in flight
      CS_FILL,                                 // Line update and snoop action
      CS_ACK                                   // Ack cycle on the served port
   } ctrl_state_t;

   ctrl_state_t        state;
   ctrl_state_t        state_nxt;
   bus_op_t            op;                     // Action from the current lookup
   bus_op_t            op_q;                   // Action held past the lookup cycle
   logic               last_port;              // Port served most recently
   logic               req_port;               // Port being served
   logic               req_we;
   logic [ADDR_W-1:0]  req_adr;
   logic [DATA_W-1:0]  req_dat;
   logic [DATA_W-1:0]  dat_r_q;
   logic               req0;
   logic               req1;
   logic               grant;
   logic               need_wb;
   logic               own_hit;                // Requester's cache view
   mesi_state_t        own_state;
   logic [DATA_W-1:0]  own_data;
   logic [TAG_W-1:0]   own_vtag;
   logic               oth_hit;                // Snooped cache view
   mesi_state_t        oth_state;
   logic [DATA_W-1:0]  oth_data;
   logic               own_wr_en;
   logic [DATA_W-1:0]  own_wr_data;
   mesi_state_t        own_wr_state;
   logic               oth_st_en;
   mesi_state_t        oth_st_state;
   logic               ack_set;                // Ack goes high next cycle
   logic [DATA_W-1:0]  rd_val;

   assign req0  = p0_cyc & p0_stb;
   assign req1  = p1_cyc & p1_stb;
   assign grant = (req0 & req1) ? ~last_port : req1;   // Round robin on a tie

   // Requester and snooper swap roles with the served port
   assign own_hit   = req_port ? c1_hit : c0_hit;
   assign own_state = req_port ? c1_state : c0_state;
   assign own_data  = req_port ? c1_data : c0_data;
   assign own_vtag  = req_port ? c1_victim_tag : c0_victim_tag;
   assign oth_hit   = req_port ? c0_hit : c1_hit;
   assign oth_state = req_port ? c0_state : c1_state;
   assign oth_data  = req_port ? c0_data : c1_data;

   // Miss on a dirty slot, so the old line goes out first
   assign need_wb = ~own_hit && (own_state == ST_M);

   // MESI action from both lookups
   always_comb
   begin
      if (req_we)
      begin
         if (own_hit)
            op = (own_state == ST_S) ? OP_UPGR : OP_NONE;   // S needs the others killed
         else
            op = OP_RDX;
      end
      else if (own_hit)
         op = OP_NONE;
      else if (oth_hit)
         op = OP_RD_SHARED;                  // Other cache supplies the word
      else
         op = OP_RD;
   end

   // Sequencer and datapath control
   always_comb
   begin
      state_nxt    = state;
      own_wr_en    = 1'b0;
      own_wr_data  = req_dat;                // Store data unless a fill says otherwise
      own_wr_state = ST_M;
      oth_st_en    = 1'b0;
      oth_st_state = ST_I;
      mem_adr      = req_adr;
      mem_re       = 1'b0;
      mem_we       = 1'b0;
      mem_wdata    = oth_data;               // Flush from the snooped M line
      ack_set      = 1'b0;
      rd_val       = own_data;
      case (state)
         CS_IDLE:
         begin
            if (req0 | req1)
               state_nxt = CS_LOOKUP;
         end
         CS_LOOKUP:
         begin
            if (need_wb)
               state_nxt = CS_WB;
            else if (op == OP_RD)
               state_nxt = CS_MEM;
            else if (op == OP_NONE)
            begin
               own_wr_en = req_we;           // Write hit in E or M, line becomes M
               ack_set   = 1'b1;
               state_nxt = CS_ACK;
            end
            else
               state_nxt = CS_FILL;
         end
         CS_WB:
         begin
            mem_we    = 1'b1;
            mem_adr   = {own_vtag, req_adr[INDEX_W-1:0]};   // Victim's own address
            mem_wdata = own_data;
            state_nxt = (op_q == OP_RD) ? CS_MEM : CS_FILL;
         end
         CS_MEM:
         begin
            mem_re    = 1'b1;                // Word arrives in the fill cycle
            state_nxt = CS_FILL;
         end
         CS_FILL:
         begin
            own_wr_en = 1'b1;
            ack_set   = 1'b1;
            state_nxt = CS_ACK;
            case (op_q)
               OP_RD:
               begin
                  own_wr_data  = mem_rdata;
                  own_wr_state = ST_E;       // Nobody else holds it
                  rd_val       = mem_rdata;
               end
               OP_RD_SHARED:
               begin
                  own_wr_data  = oth_data;
                  own_wr_state = ST_S;
                  rd_val       = oth_data;
                  oth_st_en    = 1'b1;       // E, S or M all end in S
                  oth_st_state = ST_S;
                  mem_we       = (oth_state == ST_M);   // Dirty copy flushed on the way
               end
               default:
               begin
                  oth_st_en = oth_hit;       // RDX or upgrade, other copy to I
               end
            endcase
         end
         CS_ACK:
         begin
            state_nxt = CS_IDLE;             // Master drops stb by now
         end
         default:
         begin
            state_nxt = CS_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         state     <= CS_IDLE;
         last_port <= 1'b0;                  // Port 1 wins the first tie
         req_port  <= 1'b0;
         op_q      <= OP_NONE;
         p0_ack    <= 1'b0;
         p1_ack    <= 1'b0;
      end
      else
      begin
         state  <= state_nxt;
         p0_ack <= ack_set & ~req_port;      // Single cycle, served port only
         p1_ack <= ack_set & req_port;
         if ((state == CS_IDLE) && (req0 | req1))
         begin
            req_port  <= grant;
            last_port <= grant;
         end
         if (state == CS_LOOKUP)
            op_q <= op;
      end
   end

   // Request capture and read data
   always_ff @(posedge clk)
   begin
      if (state == CS_IDLE)
      begin
         req_we  <= grant ? p1_we : p0_we;
         req_adr <= grant ? p1_adr : p0_adr;
         req_dat <= grant ? p1_dat_w : p0_dat_w;
      end
      if (ack_set)
         dat_r_q <= rd_val;
   end

   assign p0_dat_r = dat_r_q;                // Only meaningful with ack
   assign p1_dat_r = dat_r_q;

   assign lookup_adr = req_adr;

   // Requester gets line writes, snooped cache gets state updates
   assign c0_wr_en    = own_wr_en & ~req_port;
   assign c1_wr_en    = own_wr_en & req_port;
   assign c0_wr_adr   = req_adr;
   assign c1_wr_adr   = req_adr;
   assign c0_wr_data  = own_wr_data;
   assign c1_wr_data  = own_wr_data;
   assign c0_wr_state = own_wr_state;
   assign c1_wr_state = own_wr_state;
   assign c0_st_en    = oth_st_en & req_port;   // Cache 0 snooped while port 1 served
   assign c1_st_en    = oth_st_en & ~req_port;
   assign c0_st_state = oth_st_state;
   assign c1_st_state = oth_st_state;

endmodule

`default_nettype wire

/* mesi_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module mesi_cache (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic [mesi_pkg::ADDR_W-1:0]      lookup_adr,  // Shared snoop/lookup address
   input  logic                             wr_en,       // Full line write
   input  logic [mesi_pkg::ADDR_W-1:0]      wr_adr,
   input  logic [mesi_pkg::DATA_W-1:0]      wr_data,
   input  mesi_pkg::mesi_state_t            wr_state,
   input  logic                             st_en,       // State-only update at lookup_adr
   input  mesi_pkg::mesi_state_t            st_state,
   output logic                             hit,
   output mesi_pkg::mesi_state_t            line_state,
   output logic [mesi_pkg::DATA_W-1:0]      line_data,
   output logic [mesi_pkg::TAG_W-1:0]       victim_tag
);

   import mesi_pkg::*;

   logic [TAG_W-1:0]  tag_mem   [NUM_LINES];   // Tag per line
   logic [DATA_W-1:0] data_mem  [NUM_LINES];   // One word per line
   mesi_state_t       state_mem [NUM_LINES];   // MESI state per line

   logic [INDEX_W-1:0] lk_idx;
   logic [TAG_W-1:0]   lk_tag;
   logic [INDEX_W-1:0] wr_idx;
   logic [TAG_W-1:0]   wr_tag;

   // Address split, index from the low bits and tag from the high bits
   assign lk_idx = lookup_adr[INDEX_W-1:0];
   assign lk_tag = lookup_adr[ADDR_W-1:INDEX_W];
   assign wr_idx = wr_adr[INDEX_W-1:0];
   assign wr_tag = wr_adr[ADDR_W-1:INDEX_W];

   // Combinational lookup of the indexed line
   assign line_state = state_mem[lk_idx];
   assign line_data  = data_mem[lk_idx];
   assign victim_tag = tag_mem[lk_idx];          // Tag of whatever sits in the slot now
   assign hit        = (tag_mem[lk_idx] == lk_tag) && (state_mem[lk_idx] != ST_I);

   // State array with synchronous clear
   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < NUM_LINES; i++)
         begin
            state_mem[i] <= ST_I;                // All lines invalid
         end
      end
      else if (wr_en)
      begin
         state_mem[wr_idx] <= wr_state;          // Fill or local write
      end
      else if (st_en)
      begin
         state_mem[lk_idx] <= st_state;          // Snoop downgrade or invalidate
      end
   end

   // Tag and data arrays
   always_ff @(posedge clk)
   begin
      if (wr_en)
      begin
         tag_mem[wr_idx]  <= wr_tag;
         data_mem[wr_idx] <= wr_data;            // Whole line replaced
      end
   end

endmodule

`default_nettype wire

/* mesi_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module mesi_memory (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic [mesi_pkg::ADDR_W-1:0]  mem_adr,
   input  logic                         mem_re,     // Read strobe, data next cycle
   input  logic                         mem_we,     // Write strobe
   input  logic [mesi_pkg::DATA_W-1:0]  mem_wdata,
   output logic [mesi_pkg::DATA_W-1:0]  mem_rdata   // Registered read data
);

   import mesi_pkg::*;

   logic [DATA_W-1:0] mem_array [MEM_WORDS];   // Backing store

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < MEM_WORDS; i++)
         begin
            mem_array[i] <= '0;                 // Memory starts all zero
         end
      end
      else if (mem_we)
      begin
         mem_array[mem_adr] <= mem_wdata;       // Write-back or flush
      end
   end

   // Registered read port
   always_ff @(posedge clk)
   begin
      if (mem_re)
      begin
         mem_rdata <= mem_array[mem_adr];
      end
   end

endmodule

`default_nettype wire

/* mesi_pkg.sv */
`default_nettype none

package mesi_pkg;

   localparam int DATA_W    = 32;            // Data word width
   localparam int ADDR_W    = 5;             // Word address width
   localparam int MEM_WORDS = 32;            // Main memory depth
   localparam int NUM_LINES = 4;             // Lines per cache
   localparam int INDEX_W   = 2;             // Low address bits select the line
   localparam int TAG_W     = 3;             // High address bits form the tag

   // Line state, 2 bits per line
   typedef enum logic [1:0] {
      ST_I = 2'b00,                          // Invalid
      ST_E = 2'b01,                          // Exclusive, clean
      ST_S = 2'b10,                          // Shared, clean
      ST_M = 2'b11                           // Modified, dirty
   } mesi_state_t;

   // Coherence action picked by the controller for one request
   typedef enum logic [2:0] {
      OP_NONE      = 3'd0,                   // Hit, no bus traffic
      OP_RD        = 3'd1,                   // Read miss, fill from memory
      OP_RD_SHARED = 3'd2,                   // Read miss, fill from the other cache
      OP_RDX       = 3'd3,                   // Write miss, take ownership
      OP_UPGR      = 3'd4                    // Write hit in S, kill other copy
   } bus_op_t;

endpackage

`default_nettype wire

/* mesi_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module mesi_sva (
   input  logic clk,
   input  logic rst_n,
   input  logic p0_cyc,
   input  logic p0_stb,
   input  logic p0_ack,
   input  logic p1_cyc,
   input  logic p1_stb,
   input  logic p1_ack
);

   int unsigned fail_count = 0;                 // Failed assertion count

   // Ack only answers a live Wishbone request
   ack0_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      p0_ack |-> (p0_cyc && p0_stb))
   else
   begin
      $error("p0 ack while p0 cyc or stb is low");
      fail_count++;
   end

   ack1_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
      p1_ack |-> (p1_cyc && p1_stb))
   else
   begin
      $error("p1 ack while p1 cyc or stb is low");
      fail_count++;
   end

   // One request in service, so acks are exclusive
   acks_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
      !(p0_ack && p1_ack))
   else
   begin
      $error("p0 and p1 ack in the same cycle");
      fail_count++;
   end

   ack0_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      p0_ack |=> !p0_ack)
   else
   begin
      $error("p0 ack held longer than one cycle");
      fail_count++;
   end

   ack1_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      p1_ack |=> !p1_ack)
   else
   begin
      $error("p1 ack held longer than one cycle");
      fail_count++;
   end

endmodule

bind mesi_bus_ctrl mesi_sva u_handshake_sva (
   .clk    (clk),
   .rst_n  (rst_n),
   .p0_cyc (p0_cyc),
   .p0_stb (p0_stb),
   .p0_ack (p0_ack),
   .p1_cyc (p1_cyc),
   .p1_stb (p1_stb),
   .p1_ack (p1_ack)
);

`default_nettype wire

/* mesi_system.f */
mesi_pkg.sv
mesi_cache.sv
mesi_memory.sv
mesi_bus_ctrl.sv
mesi_system.sv
mesi_sva.sv
tb_mesi_system.sv

/* mesi_system.sv */
`timescale 1ns/1ps
`default_nettype none

module mesi_system (
   input  logic                         clk,
   input  logic                         rst_n,
   input  logic                         p0_cyc,
   input  logic                         p0_stb,
   input  logic                         p0_we,
   input  logic [mesi_pkg::ADDR_W-1:0]  p0_adr,
   input  logic [mesi_pkg::DATA_W-1:0]  p0_dat_w,
   output logic [mesi_pkg::DATA_W-1:0]  p0_dat_r,
   output logic                         p0_ack,
   input  logic                         p1_cyc,
   input  logic                         p1_stb,
   input  logic                         p1_we,
   input  logic [mesi_pkg::ADDR_W-1:0]  p1_adr,
   input  logic [mesi_pkg::DATA_W-1:0]  p1_dat_w,
   output logic [mesi_pkg::DATA_W-1:0]  p1_dat_r,
   output logic                         p1_ack
);

   import mesi_pkg::*;

   logic [ADDR_W-1:0]  lookup_adr;           // Shared snoop address
   logic               c0_hit;
   mesi_state_t        c0_state;
   logic [DATA_W-1:0]  c0_data;
   logic [TAG_W-1:0]   c0_victim_tag;
   logic               c0_wr_en;
   logic [ADDR_W-1:0]  c0_wr_adr;
   logic [DATA_W-1:0]  c0_wr_data;
   mesi_state_t        c0_wr_state;
   logic               c0_st_en;
   mesi_state_t        c0_st_state;
   logic               c1_hit;
   mesi_state_t        c1_state;
   logic [DATA_W-1:0]  c1_data;
   logic [TAG_W-1:0]   c1_victim_tag;
   logic               c1_wr_en;
   logic [ADDR_W-1:0]  c1_wr_adr;
   logic [DATA_W-1:0]  c1_wr_data;
   mesi_state_t        c1_wr_state;
   logic               c1_st_en;
   mesi_state_t        c1_st_state;
   logic [ADDR_W-1:0]  mem_adr;
   logic               mem_re;
   logic               mem_we;
   logic [DATA_W-1:0]  mem_wdata;
   logic [DATA_W-1:0]  mem_rdata;

   mesi_bus_ctrl u_bus_ctrl (.*);            // Port names match the wires above

   mesi_cache u_cache0 (                     // Processor 0 cache
      .clk        (clk),
      .rst_n      (rst_n),
      .lookup_adr (lookup_adr),
      .wr_en      (c0_wr_en),
      .wr_adr     (c0_wr_adr),
      .wr_data    (c0_wr_data),
      .wr_state   (c0_wr_state),
      .st_en      (c0_st_en),
      .st_state   (c0_st_state),
      .hit        (c0_hit),
      .line_state (c0_state),
      .line_data  (c0_data),
      .victim_tag (c0_victim_tag)
   );

   mesi_cache u_cache1 (                     // Processor 1 cache
      .clk        (clk),
      .rst_n      (rst_n),
      .lookup_adr (lookup_adr),
      .wr_en      (c1_wr_en),
      .wr_adr     (c1_wr_adr),
      .wr_data    (c1_wr_data),
      .wr_state   (c1_wr_state),
      .st_en      (c1_st_en),
      .st_state   (c1_st_state),
      .hit        (c1_hit),
      .line_state (c1_state),
      .line_data  (c1_data),
      .victim_tag (c1_victim_tag)
   );

   mesi_memory u_memory (
      .clk       (clk),
      .rst_n     (rst_n),
      .mem_adr   (mem_adr),
      .mem_re    (mem_re),
      .mem_we    (mem_we),
      .mem_wdata (mem_wdata),
      .mem_rdata (mem_rdata)
   );

endmodule

`default_nettype wire

/* run.sh */
#!/usr/bin/env bash
# Build and run the MESI system testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
      --top-module tb_mesi_system -f mesi_system.f -o tb_mesi_system; then
   echo "Verilator build failed"
   exit 1
fi

# Assertion errors are counted by the testbench, so the run keeps going past them
sim_out=$(./obj_dir/tb_mesi_system +verilator+error+limit+1000)
sim_rc=$?
echo "$sim_out"
if [ $sim_rc -ne 0 ]; then
   echo "Simulation exited with status $sim_rc"
   exit 1
fi

if grep -qF '*** PASSED ***' <<< "$sim_out"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb_mesi_system.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mesi_system;

   import mesi_pkg::*;

   localparam int N_RAND     = 400;                // Random ops over both ports
   localparam int N_HALF     = N_RAND / 2;
   localparam int N_PAIRS    = 8;                  // Simultaneous request pairs
   localparam int MAX_CYCLES = N_RAND * 12;        // Covers directed phases too

   logic               clk;
   logic               rst_n;
   logic [1:0]         cyc;                        // Bit index is the port
   logic [1:0]         stb;
   logic [1:0]         we;
   logic [ADDR_W-1:0]  adr   [2];
   logic [DATA_W-1:0]  dat_w [2];
   logic [DATA_W-1:0]  p0_dat_r;
   logic [DATA_W-1:0]  p1_dat_r;
   logic               p0_ack;
   logic               p1_ack;

   logic [DATA_W-1:0]  latest  [MEM_WORDS];        // Newest value of every word
   mesi_state_t        m_state [2][NUM_LINES];     // Expected line states
   logic [TAG_W-1:0]   m_tag   [2][NUM_LINES];
   int                 last_served;                // Decides the next tie

   logic               rnd_we  [2][N_HALF];
   logic [ADDR_W-1:0]  rnd_adr [2][N_HALF];
   logic [DATA_W-1:0]  rnd_dat [2][N_HALF];
   int                 rnd_gap [2][N_HALF];        // Idle cycles before each op

   integer             seed;
   int                 n_checks;
   int                 n_errors;
   int                 cycle_cnt;

   mesi_system UUT (
      .clk      (clk),
      .rst_n    (rst_n),
      .p0_cyc   (cyc[0]),
      .p0_stb   (stb[0]),
      .p0_we    (we[0]),
      .p0_adr   (adr[0]),
      .p0_dat_w (dat_w[0]),
      .p0_dat_r (p0_dat_r),
      .p0_ack   (p0_ack),
      .p1_cyc   (cyc[1]),
      .p1_stb   (stb[1]),
      .p1_we    (we[1]),
      .p1_adr   (adr[1]),
      .p1_dat_w (dat_w[1]),
      .p1_dat_r (p1_dat_r),
      .p1_ack   (p1_ack)
   );

   always #5 clk = ~clk;                           // 10 ns period

   task automatic check_val(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                            input string msg);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("Mismatch at %0t: %s, got %0h, expected %0h", $time, msg, got, exp);
      end
   endtask

   // Reset for 4 cycles, model back to empty caches and zero memory
   task automatic apply_reset();
      rst_n = 1'b0;
      cyc   = 2'b00;
      stb   = 2'b00;
      we    = 2'b00;
      for (int p = 0; p < 2; p++)
      begin
         adr[p]   = '0;
         dat_w[p] = '0;
         for (int i = 0; i < NUM_LINES; i++)
         begin
            m_state[p][i] = ST_I;
            m_tag[p][i]   = '0;
         end
      end
      for (int a = 0; a < MEM_WORDS; a++)
         latest[a] = '0;
      last_served = 0;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
   endtask

   // One Wishbone transfer, cycles counted from the drive to the ack
   task automatic do_op(input int port, input logic op_we, input logic [ADDR_W-1:0] op_adr,
                        input logic [DATA_W-1:0] op_dat, output logic [DATA_W-1:0] rdata,
                        output int ncyc);
      logic got_ack;
      cyc[port]   = 1'b1;
      stb[port]   = 1'b1;
      we[port]    = op_we;
      adr[port]   = op_adr;
      dat_w[port] = op_dat;
      ncyc        = 0;
      got_ack     = 1'b0;
      while (!got_ack)
      begin
         @(posedge clk);
         #1;
         ncyc++;
         got_ack = port ? p1_ack : p0_ack;
      end
      rdata = port ? p1_dat_r : p0_dat_r;      // Valid in the ack cycle
      @(posedge clk);
      #1;
      cyc[port] = 1'b0;                          // Dropped after the ack cycle
      stb[port] = 1'b0;
   endtask

   // MESI reference, called in service order
   task automatic model_access(input int port, input logic op_we,
                               input logic [ADDR_W-1:0] op_adr, input logic [DATA_W-1:0] op_dat,
                               output logic [DATA_W-1:0] exp_rd, output int exp_lat);
      int                 other;
      logic [INDEX_W-1:0] idx;
      logic [TAG_W-1:0]   tag;
      logic               own_hit;
      logic               oth_hit;
      logic               dirty_victim;
      other        = 1 - port;
      idx          = op_adr[INDEX_W-1:0];
      tag          = op_adr[ADDR_W-1:INDEX_W];
      own_hit      = (m_state[port][idx] != ST_I) && (m_tag[port][idx] == tag);
      oth_hit      = (m_state[other][idx] != ST_I) && (m_tag[other][idx] == tag);
      dirty_victim = !own_hit && (m_state[port][idx] == ST_M);
      exp_rd       = latest[op_adr];
      if (op_we)
      begin
         if (own_hit && (m_state[port][idx] == ST_S))
            exp_lat = 3;                         // Upgrade
         else if (own_hit)
            exp_lat = 2;                         // Silent E or M hit
         else
            exp_lat = 3;                         // Read for ownership
         if (oth_hit)
            m_state[other][idx] = ST_I;
         m_state[port][idx] = ST_M;
         latest[op_adr]     = op_dat;
      end
      else if (own_hit)
         exp_lat = 2;
      else if (oth_hit)
      begin
         exp_lat             = 3;                // Cache to cache, both end shared
         m_state[other][idx] = ST_S;
         m_state[port][idx]  = ST_S;
      end
      else
      begin
         exp_lat            = 4;                 // Memory fill
         m_state[port][idx] = ST_E;
      end
      if (dirty_victim)
         exp_lat++;                              // Victim written back first
      m_tag[port][idx] = tag;
      last_served      = port;
   endtask

   // Lone request, so acceptance is the first edge
   task automatic single_op(input int port, input logic op_we, input logic [ADDR_W-1:0] op_adr,
                            input logic [DATA_W-1:0] op_dat);
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] exp_rd;
      int                n;
      int                exp_lat;
      do_op(port, op_we, op_adr, op_dat, rd, n);
      model_access(port, op_we, op_adr, op_dat, exp_rd, exp_lat);
      check_val(n, exp_lat, $sformatf("p%0d latency, word %0d, we %0b", port, op_adr, op_we));
      if (!op_we)
         check_val(rd, exp_rd, $sformatf("p%0d read of word %0d", port, op_adr));
   endtask

   // Both ports request in the same cycle
   task automatic pair_op(input logic [1:0] pwe, input logic [ADDR_W-1:0] a0,
                          input logic [ADDR_W-1:0] a1, input logic [DATA_W-1:0] d0,
                          input logic [DATA_W-1:0] d1);
      logic [DATA_W-1:0] rd     [2];
      logic [DATA_W-1:0] exp_rd [2];
      logic [ADDR_W-1:0] pa     [2];
      logic [DATA_W-1:0] pd     [2];
      int                n      [2];
      int                lat    [2];
      int                first;
      int                second;
      pa[0]  = a0;
      pa[1]  = a1;
      pd[0]  = d0;
      pd[1]  = d1;
      first  = 1 - last_served;                  // Round robin winner
      second = last_served;
      fork
         do_op(0, pwe[0], a0, d0, rd[0], n[0]);
         do_op(1, pwe[1], a1, d1, rd[1], n[1]);
      join
      model_access(first, pwe[first], pa[first], pd[first], exp_rd[first], lat[first]);
      model_access(second, pwe[second], pa[second], pd[second], exp_rd[second], lat[second]);
      check_val(n[first], lat[first], $sformatf("p%0d latency as tie winner", first));
      check_val(n[second], lat[first] + 1 + lat[second],
                $sformatf("p%0d latency served after p%0d", second, first));
      for (int p = 0; p < 2; p++)
      begin
         if (!pwe[p])
            check_val(rd[p], exp_rd[p], $sformatf("p%0d paired read of word %0d", p, pa[p]));
      end
   endtask

   // One port's share of the random traffic
   task automatic rand_port(input int port);
      logic [DATA_W-1:0] rd;
      logic [DATA_W-1:0] exp_rd;
      int                n;
      int                exp_lat;
      for (int i = 0; i < N_HALF; i++)
      begin
         repeat (rnd_gap[port][i])
         begin
            @(posedge clk);
            #1;
         end
         do_op(port, rnd_we[port][i], rnd_adr[port][i], rnd_dat[port][i], rd, n);
         model_access(port, rnd_we[port][i], rnd_adr[port][i], rnd_dat[port][i],
                      exp_rd, exp_lat);
         if (!rnd_we[port][i])
            check_val(rd, exp_rd,
                      $sformatf("p%0d random read of word %0d", port, rnd_adr[port][i]));
      end
   endtask

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < MAX_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("*** FAILED ***");
      $finish;
   end

   initial
   begin
      logic [31:0] r;
      logic [31:0] d0;
      logic [31:0] d1;
      int          sva_fails;
      seed     = 89;
      clk      = 1'b0;
      n_checks = 0;
      n_errors = 0;
      apply_reset();

      // Acks idle, first reads come from zeroed memory
      check_val(p0_ack, 1'b0, "p0 ack after reset");
      check_val(p1_ack, 1'b0, "p1 ack after reset");
      single_op(0, 1'b0, 5'd5, '0);
      single_op(1, 1'b0, 5'd14, '0);

      // Directed MESI transitions on word 5
      single_op(0, 1'b0, 5'd5, '0);              // Read hit E
      single_op(0, 1'b1, 5'd5, 32'h1111_0005);   // Write hit E, to M
      single_op(0, 1'b0, 5'd5, '0);              // Read hit M
      single_op(1, 1'b0, 5'd5, '0);              // Shared miss, M flushed
      single_op(1, 1'b0, 5'd5, '0);              // Read hit S
      single_op(0, 1'b1, 5'd5, 32'h2222_0005);   // Upgrade from S
      single_op(1, 1'b1, 5'd5, 32'h3333_0005);   // Write miss, p0 copy killed
      single_op(0, 1'b0, 5'd5, '0);              // Shared miss from M again
      single_op(0, 1'b0, 5'd14, '0);             // Shared miss from E
      single_op(0, 1'b0, 5'd9, '0);              // Memory miss

      // Same index, every tag, so each write evicts a dirty line
      for (int t = 0; t < 8; t++)
      begin
         r = $random(seed);
         single_op(0, 1'b1, 5'(4 * t + 3), r);
      end
      for (int t = 0; t < 8; t++)
         single_op(1, 1'b0, 5'(4 * t + 3), '0);

      // Arbitration from a fresh reset, port 1 first
      apply_reset();
      pair_op(2'b00, 5'd6, 5'd6, '0, '0);
      for (int k = 0; k < N_PAIRS; k++)
      begin
         r  = $random(seed);
         d0 = $random(seed);
         d1 = $random(seed);
         single_op(k % 2, 1'b0, r[16:12], '0);   // Served port loses the next tie
         pair_op(r[1:0], r[6:2], r[11:7], d0, d1);
      end

      // Concurrent random traffic
      for (int p = 0; p < 2; p++)
      begin
         for (int i = 0; i < N_HALF; i++)
         begin
            r             = $random(seed);
            rnd_we[p][i]  = r[0];
            rnd_adr[p][i] = r[5:1];
            rnd_gap[p][i] = int'(r[7:6]);
            rnd_dat[p][i] = $random(seed);
         end
      end
      fork
         rand_port(0);
         rand_port(1);
      join

      sva_fails = UUT.u_bus_ctrl.u_handshake_sva.fail_count;
      $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
               n_checks, n_errors, sva_fails);
      if ((n_errors == 0) && (sva_fails == 0))
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire
